//--- src/mmu_config.svh
/*
 * MMU region parameters
 * Address, page, TLB, length and pid widths, DMA command size, credit count
 */
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// Address widths
`define MMU_VADDR_BITS 32
`define MMU_PADDR_BITS 32

// 4 KiB pages
`define MMU_PG_BITS 12

// Direct-mapped TLB with 16 entries
`define MMU_TLB_ORDER 4

// Request fields
`define MMU_PID_BITS 6
`define MMU_LEN_BITS 16

// Largest single DMA command in bytes
`define MMU_XFER_BYTES 256

// Commands in flight per direction
`define MMU_N_CREDITS 4

`endif

//--- src/mmu_pkg.sv
/*
 * MMU types
 * Address, length, pid and TLB field vectors, translation FSM states
 */
`default_nettype none

`include "mmu_config.svh"

package mmu_pkg;

  // Request fields
  typedef logic [`MMU_VADDR_BITS-1:0] vaddr_t;
  typedef logic [`MMU_PADDR_BITS-1:0] paddr_t;
  typedef logic [`MMU_LEN_BITS-1:0]   len_t;
  typedef logic [`MMU_PID_BITS-1:0]   pid_t;

  // Physical page number
  typedef logic [`MMU_PADDR_BITS-`MMU_PG_BITS-1:0] ppn_t;

  // TLB index from the low virtual page bits, tag from the rest
  typedef logic [`MMU_TLB_ORDER-1:0] tlb_idx_t;
  typedef logic [`MMU_VADDR_BITS-`MMU_PG_BITS-`MMU_TLB_ORDER-1:0] tlb_tag_t;

  // Translation FSM
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_WAIT,
    ST_ISSUE,
    ST_FAULT,
    ST_UNLOCK
  } xlat_state_t;

endpackage

`default_nettype wire

//--- src/mmu_if.sv
/*
 * DMA request interface, used before and after translation
 * TLB lookup interface between FSMs, lock and store
 */
`timescale 1ns/100ps
`default_nettype none

interface dma_req_if import mmu_pkg::*; ();
  logic   valid;
  logic   ready;
  // Virtual or physical, both 32 bits wide
  vaddr_t addr;
  len_t   len;
  pid_t   pid;

  modport src (
    output valid, addr, len, pid,
    input  ready
  );

  modport dst (
    input  valid, addr, len, pid,
    output ready
  );
endinterface

interface tlb_lookup_if import mmu_pkg::*; ();
  logic   valid;
  vaddr_t vaddr;
  pid_t   pid;
  // Result one cycle after valid
  logic   hit;
  ppn_t   ppn;

  modport client (
    output valid, vaddr, pid,
    input  hit, ppn
  );

  modport server (
    input  valid, vaddr, pid,
    output hit, ppn
  );
endinterface

`default_nettype wire

//--- src/tlb_store.sv
/*
 * Direct-mapped TLB
 * One fill strobe port, one lookup port with registered hit and ppn
 */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_config.svh"

module tlb_store import mmu_pkg::*; (
  input  logic         aclk,
  input  logic         aresetn,
  input  logic         fill_valid,
  input  vaddr_t       fill_vaddr,
  input  pid_t         fill_pid,
  input  ppn_t         fill_ppn,
  input  logic         fill_entry_valid,
  tlb_lookup_if.server lookup
);

  localparam int unsigned N_ENTRIES = 1 << `MMU_TLB_ORDER;
  localparam int unsigned TAG_LSB = `MMU_PG_BITS + `MMU_TLB_ORDER;

  // Entry arrays, only the valid bits are cleared
  logic [N_ENTRIES-1:0] ent_valid;
  tlb_tag_t             ent_tag [N_ENTRIES];
  pid_t                 ent_pid [N_ENTRIES];
  ppn_t                 ent_ppn [N_ENTRIES];

  tlb_idx_t fill_idx;
  tlb_tag_t fill_tag;
  tlb_idx_t look_idx;
  tlb_tag_t look_tag;

  assign fill_idx = fill_vaddr[`MMU_PG_BITS +: `MMU_TLB_ORDER];
  assign fill_tag = fill_vaddr[`MMU_VADDR_BITS-1:TAG_LSB];
  assign look_idx = lookup.vaddr[`MMU_PG_BITS +: `MMU_TLB_ORDER];
  assign look_tag = lookup.vaddr[`MMU_VADDR_BITS-1:TAG_LSB];

  // ----------------------------------------
  // Fill
  // ----------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      ent_valid <= '0;
    end else if (fill_valid) begin
      // Clearing the bit invalidates the entry
      ent_valid[fill_idx] <= fill_entry_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (fill_valid) begin
      ent_tag[fill_idx] <= fill_tag;
      ent_pid[fill_idx] <= fill_pid;
      ent_ppn[fill_idx] <= fill_ppn;
    end
  end

  // ----------------------------------------
  // Lookup
  // ----------------------------------------
  // Reads the old entry when a fill lands on the same cycle
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      lookup.hit <= 1'b0;
    end else begin
      lookup.hit <= lookup.valid && ent_valid[look_idx] &&
                    (ent_tag[look_idx] == look_tag) && (ent_pid[look_idx] == lookup.pid);
    end
  end

  always_ff @(posedge aclk) begin
    if (lookup.valid) begin
      lookup.ppn <= ent_ppn[look_idx];
    end
  end

  // Owner's address must be settled whenever it looks up
  a_lookup_known: assert property (@(posedge aclk) disable iff (!aresetn)
    lookup.valid |-> !$isunknown(lookup.vaddr));

endmodule

`default_nettype wire

//--- src/tlb_lock.sv
/*
 * Two-owner lock over the shared TLB
 * Steers the owner's lookup to the store, result goes to both
 */
`timescale 1ns/100ps
`default_nettype none

module tlb_lock (
  input  logic         aclk,
  input  logic         aresetn,
  input  logic         rd_lock,
  input  logic         wr_lock,
  input  logic         rd_unlock,
  input  logic         wr_unlock,
  output logic         rd_grant,
  output logic         wr_grant,
  tlb_lookup_if.server rd_tlb,
  tlb_lookup_if.server wr_tlb,
  tlb_lookup_if.client tlb
);

  // Bit 0 free, bit 1 selects the write owner
  localparam logic [1:0] LOCK_FREE = 2'b01;
  localparam logic [1:0] LOCK_RD   = 2'b00;
  localparam logic [1:0] LOCK_WR   = 2'b10;

  logic [1:0] mutex;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      mutex <= LOCK_FREE;
    end else if (mutex == LOCK_FREE) begin
      // Read side wins a tie
      if (rd_lock) begin
        mutex <= LOCK_RD;
      end else if (wr_lock) begin
        mutex <= LOCK_WR;
      end
    end else if ((mutex == LOCK_RD && rd_unlock) || (mutex == LOCK_WR && wr_unlock)) begin
      mutex <= LOCK_FREE;
    end
  end

  assign rd_grant = (mutex == LOCK_RD);
  assign wr_grant = (mutex == LOCK_WR);

  // Only the owner reaches the store
  assign tlb.valid = (rd_grant && rd_tlb.valid) || (wr_grant && wr_tlb.valid);
  assign tlb.vaddr = wr_grant ? wr_tlb.vaddr : rd_tlb.vaddr;
  assign tlb.pid   = wr_grant ? wr_tlb.pid : rd_tlb.pid;

  // Broadcast, the idle side ignores it
  assign rd_tlb.hit = tlb.hit;
  assign rd_tlb.ppn = tlb.ppn;
  assign wr_tlb.hit = tlb.hit;
  assign wr_tlb.ppn = tlb.ppn;

  // Only the current owner gives the lock back
  a_rd_unlock_owner: assert property (@(posedge aclk) disable iff (!aresetn)
    rd_unlock |-> rd_grant);
  a_wr_unlock_owner: assert property (@(posedge aclk) disable iff (!aresetn)
    wr_unlock |-> wr_grant);

endmodule

`default_nettype wire

//--- src/xlat_fsm.sv
/*
 * Per-direction translation FSM
 * Page walk under the TLB lock, page-fault handshake, one run per page
 */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_config.svh"

module xlat_fsm import mmu_pkg::*; (
  input  logic         aclk,
  input  logic         aresetn,
  dma_req_if.dst       req,
  tlb_lookup_if.client tlb,
  output logic         lock,
  output logic         unlock,
  input  logic         grant,
  output logic         pfault,
  output vaddr_t       pfault_vaddr,
  input  logic         pfault_ack,
  dma_req_if.src       run
);

  localparam int unsigned PG_SIZE = 1 << `MMU_PG_BITS;

  xlat_state_t state;
  xlat_state_t state_nxt;

  // Walk position
  vaddr_t cur_vaddr;
  len_t   remaining;
  pid_t   cur_pid;

  // Run being offered
  paddr_t run_paddr;
  len_t   run_len;

  len_t   to_page_end;
  logic   last_run;

  assign to_page_end = len_t'(PG_SIZE) - len_t'(cur_vaddr[`MMU_PG_BITS-1:0]);
  assign last_run    = (run_len == remaining);

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        // Empty requests are dropped
        if (req.valid && req.len != '0) begin
          state_nxt = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        if (grant) begin
          state_nxt = ST_WAIT;
        end
      end
      ST_WAIT: begin
        state_nxt = tlb.hit ? ST_ISSUE : ST_FAULT;
      end
      ST_ISSUE: begin
        if (run.ready) begin
          state_nxt = last_run ? ST_UNLOCK : ST_LOOKUP;
        end
      end
      ST_FAULT: begin
        // Software filled the entry, retry the same page
        if (pfault_ack) begin
          state_nxt = ST_LOOKUP;
        end
      end
      ST_UNLOCK: begin
        state_nxt = ST_IDLE;
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // ----------------------------------------
  // Datapath
  // ----------------------------------------
  always_ff @(posedge aclk) begin
    if (state == ST_IDLE && req.valid) begin
      cur_vaddr <= req.addr;
      remaining <= req.len;
      cur_pid   <= req.pid;
    end else if (state == ST_WAIT && tlb.hit) begin
      // Rest of the request, capped at the page end
      run_paddr <= {tlb.ppn, cur_vaddr[`MMU_PG_BITS-1:0]};
      run_len   <= (remaining < to_page_end) ? remaining : to_page_end;
    end else if (state == ST_ISSUE && run.ready) begin
      cur_vaddr <= cur_vaddr + vaddr_t'(run_len);
      remaining <= remaining - run_len;
    end
  end

  // Outputs
  assign req.ready = (state == ST_IDLE);
  assign lock      = (state == ST_LOOKUP);
  assign unlock    = (state == ST_UNLOCK);

  assign tlb.valid = (state == ST_LOOKUP) && grant;
  assign tlb.vaddr = cur_vaddr;
  assign tlb.pid   = cur_pid;

  // Fault reports the page base
  assign pfault       = (state == ST_FAULT);
  assign pfault_vaddr = {cur_vaddr[`MMU_VADDR_BITS-1:`MMU_PG_BITS], {`MMU_PG_BITS{1'b0}}};

  assign run.valid = (state == ST_ISSUE);
  assign run.addr  = run_paddr;
  assign run.len   = run_len;
  assign run.pid   = cur_pid;

  // Software acknowledges only a raised fault
  a_ack_in_fault: assert property (@(posedge aclk) disable iff (!aresetn)
    pfault_ack |-> pfault);

endmodule

`default_nettype wire

//--- src/dma_splitter.sv
/*
 * Run splitter
 * Cuts a physical run into commands that never cross a transfer boundary
 */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_config.svh"

module dma_splitter import mmu_pkg::*; (
  input  logic   aclk,
  input  logic   aresetn,
  dma_req_if.dst run,
  dma_req_if.src cmd
);

  localparam int unsigned XFER_BITS = $clog2(`MMU_XFER_BYTES);

  logic   busy;
  paddr_t cur_addr;
  len_t   remaining;
  pid_t   cur_pid;

  // Bytes up to the next transfer-aligned address
  len_t   to_bound;
  len_t   cmd_len;
  logic   cmd_fire;

  assign to_bound = len_t'(`MMU_XFER_BYTES) - len_t'(cur_addr[XFER_BITS-1:0]);
  assign cmd_len  = (remaining < to_bound) ? remaining : to_bound;
  assign cmd_fire = cmd.valid && cmd.ready;

  // One run at a time
  assign run.ready = !busy;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      busy <= 1'b0;
    end else if (run.valid && run.ready) begin
      busy <= 1'b1;
    end else if (cmd_fire && cmd_len == remaining) begin
      // Last piece leaves
      busy <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (run.valid && run.ready) begin
      cur_addr  <= run.addr;
      remaining <= run.len;
      cur_pid   <= run.pid;
    end else if (cmd_fire) begin
      cur_addr  <= cur_addr + paddr_t'(cmd_len);
      remaining <= remaining - cmd_len;
    end
  end

  // Held register doubles as the output stage
  assign cmd.valid = busy;
  assign cmd.addr  = cur_addr;
  assign cmd.len   = cmd_len;
  assign cmd.pid   = cur_pid;

endmodule

`default_nettype wire

//--- src/xfer_credits.sv
/*
 * Credit stage
 * Registered output slot, commands in flight capped until xfer returns
 */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_config.svh"

module xfer_credits import mmu_pkg::*; (
  input  logic   aclk,
  input  logic   aresetn,
  dma_req_if.dst cmd_in,
  dma_req_if.src cmd_out,
  input  logic   xfer
);

  localparam int unsigned CRED_BITS = $clog2(`MMU_N_CREDITS + 1);

  logic [CRED_BITS-1:0] credits;

  logic   out_valid;
  paddr_t out_addr;
  len_t   out_len;
  pid_t   out_pid;

  logic   in_fire;
  logic   out_fire;

  assign out_fire = out_valid && cmd_out.ready;
  assign in_fire  = cmd_in.valid && cmd_in.ready;

  // A full slot already holds one credit
  assign cmd_in.ready = out_valid ? (cmd_out.ready && credits > CRED_BITS'(1))
                                  : (credits != '0);

  // ----------------------------------------
  // Credit count
  // ----------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      credits <= CRED_BITS'(`MMU_N_CREDITS);
    end else begin
      case ({out_fire, xfer})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // Output slot
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      out_valid <= 1'b0;
    end else if (in_fire) begin
      out_valid <= 1'b1;
    end else if (out_fire) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (in_fire) begin
      out_addr <= cmd_in.addr;
      out_len  <= cmd_in.len;
      out_pid  <= cmd_in.pid;
    end
  end

  assign cmd_out.valid = out_valid;
  assign cmd_out.addr  = out_addr;
  assign cmd_out.len   = out_len;
  assign cmd_out.pid   = out_pid;

  // More xfer pulses than commands sent would overflow
  a_credit_max: assert property (@(posedge aclk) disable iff (!aresetn)
    credits <= CRED_BITS'(`MMU_N_CREDITS));

endmodule

`default_nettype wire

//--- src/mmu_region_top.sv
/*
 * MMU region top level
 * Shared TLB and lock, per-direction translation, splitter and credit stages
 */
`timescale 1ns/100ps
`default_nettype none

module mmu_region_top import mmu_pkg::*; (
  input  logic   aclk,
  input  logic   aresetn,
  // User requests
  input  logic   rd_req_valid,
  output logic   rd_req_ready,
  input  vaddr_t rd_req_vaddr,
  input  len_t   rd_req_len,
  input  pid_t   rd_req_pid,
  input  logic   wr_req_valid,
  output logic   wr_req_ready,
  input  vaddr_t wr_req_vaddr,
  input  len_t   wr_req_len,
  input  pid_t   wr_req_pid,
  // TLB fill
  input  logic   fill_valid,
  input  vaddr_t fill_vaddr,
  input  pid_t   fill_pid,
  input  ppn_t   fill_ppn,
  input  logic   fill_entry_valid,
  // Page faults
  output logic   rd_pfault,
  output vaddr_t rd_pfault_vaddr,
  input  logic   rd_pfault_ack,
  output logic   wr_pfault,
  output vaddr_t wr_pfault_vaddr,
  input  logic   wr_pfault_ack,
  // DMA commands and transfer returns
  output logic   rd_dma_valid,
  input  logic   rd_dma_ready,
  output paddr_t rd_dma_paddr,
  output len_t   rd_dma_len,
  input  logic   rd_xfer,
  output logic   wr_dma_valid,
  input  logic   wr_dma_ready,
  output paddr_t wr_dma_paddr,
  output len_t   wr_dma_len,
  input  logic   wr_xfer
);

  logic rd_lock;
  logic wr_lock;
  logic rd_unlock;
  logic wr_unlock;
  logic rd_grant;
  logic wr_grant;

  tlb_lookup_if rd_tlb ();
  tlb_lookup_if wr_tlb ();
  tlb_lookup_if tlb ();

  // Request, run, command and output stages per direction
  dma_req_if rd_req ();
  dma_req_if rd_run ();
  dma_req_if rd_cmd ();
  dma_req_if rd_dma ();
  dma_req_if wr_req ();
  dma_req_if wr_run ();
  dma_req_if wr_cmd ();
  dma_req_if wr_dma ();

  // ----------------------------------------
  // Port packing
  // ----------------------------------------
  assign rd_req.valid = rd_req_valid;
  assign rd_req.addr  = rd_req_vaddr;
  assign rd_req.len   = rd_req_len;
  assign rd_req.pid   = rd_req_pid;
  assign rd_req_ready = rd_req.ready;
  assign wr_req.valid = wr_req_valid;
  assign wr_req.addr  = wr_req_vaddr;
  assign wr_req.len   = wr_req_len;
  assign wr_req.pid   = wr_req_pid;
  assign wr_req_ready = wr_req.ready;

  assign rd_dma_valid = rd_dma.valid;
  assign rd_dma_paddr = rd_dma.addr;
  assign rd_dma_len   = rd_dma.len;
  assign rd_dma.ready = rd_dma_ready;
  assign wr_dma_valid = wr_dma.valid;
  assign wr_dma_paddr = wr_dma.addr;
  assign wr_dma_len   = wr_dma.len;
  assign wr_dma.ready = wr_dma_ready;

  // ----------------------------------------
  // Shared TLB
  // ----------------------------------------
  tlb_store u_tlb (
    .aclk, .aresetn, .fill_valid, .fill_vaddr, .fill_pid, .fill_ppn, .fill_entry_valid,
    .lookup(tlb)
  );

  tlb_lock u_lock (
    .aclk, .aresetn, .rd_lock, .wr_lock, .rd_unlock, .wr_unlock, .rd_grant, .wr_grant,
    .rd_tlb, .wr_tlb, .tlb
  );

  // ----------------------------------------
  // Direction pipelines
  // ----------------------------------------
  xlat_fsm u_rd_xlat (
    .aclk, .aresetn, .req(rd_req), .tlb(rd_tlb), .lock(rd_lock), .unlock(rd_unlock),
    .grant(rd_grant), .pfault(rd_pfault), .pfault_vaddr(rd_pfault_vaddr),
    .pfault_ack(rd_pfault_ack), .run(rd_run)
  );

  xlat_fsm u_wr_xlat (
    .aclk, .aresetn, .req(wr_req), .tlb(wr_tlb), .lock(wr_lock), .unlock(wr_unlock),
    .grant(wr_grant), .pfault(wr_pfault), .pfault_vaddr(wr_pfault_vaddr),
    .pfault_ack(wr_pfault_ack), .run(wr_run)
  );

  dma_splitter u_rd_split (.aclk, .aresetn, .run(rd_run), .cmd(rd_cmd));
  dma_splitter u_wr_split (.aclk, .aresetn, .run(wr_run), .cmd(wr_cmd));

  xfer_credits u_rd_cred (.aclk, .aresetn, .cmd_in(rd_cmd), .cmd_out(rd_dma), .xfer(rd_xfer));
  xfer_credits u_wr_cred (.aclk, .aresetn, .cmd_in(wr_cmd), .cmd_out(wr_dma), .xfer(wr_xfer));

endmodule

`default_nettype wire

//--- dv/mmu_tb_tests.svh
/*
 * Directed tests: single page, page crossing, faults,
 * both directions, credit limit, random back-pressure
 */

task automatic test_single_page();
  mark = errors;
  fill_entry(32'h0001_0000, 6'd3, 20'h00abc);
  // Unaligned start, three commands
  expect_req(1'b0, 32'h0001_0040, 700, 6'd3);
  send_req(1'b0, 32'h0001_0040, 16'd700, 6'd3);
  wait_drained();
  report_test("single page");
endtask

task automatic test_two_pages();
  mark = errors;
  fill_entry(32'h0002_0000, 6'd3, 20'h11111);
  fill_entry(32'h0002_1000, 6'd3, 20'h22222);
  expect_req(1'b0, 32'h0002_0f80, 512, 6'd3);
  send_req(1'b0, 32'h0002_0f80, 16'd512, 6'd3);
  wait_drained();
  report_test("two pages");
endtask

task automatic test_page_fault();
  mark = errors;
  // Empty entry
  send_req(1'b0, 32'h0003_5010, 16'd300, 6'd3);
  while (!rd_pfault) @(negedge aclk);
  check_vaddr("read fault address", rd_pfault_vaddr, 32'h0003_5000);
  fill_entry(32'h0003_5000, 6'd3, 20'h35035);
  expect_req(1'b0, 32'h0003_5010, 300, 6'd3);
  ack_fault(1'b0);
  wait_drained();
  // Entry owned by another process
  fill_entry(32'h0003_6000, 6'd9, 20'h36036);
  send_req(1'b0, 32'h0003_6000, 16'd128, 6'd3);
  while (!rd_pfault) @(negedge aclk);
  check_vaddr("read fault address", rd_pfault_vaddr, 32'h0003_6000);
  fill_entry(32'h0003_6000, 6'd3, 20'h36036);
  expect_req(1'b0, 32'h0003_6000, 128, 6'd3);
  ack_fault(1'b0);
  wait_drained();
  // Write side faults on its own port
  send_req(1'b1, 32'h0003_7020, 16'd64, 6'd3);
  while (!wr_pfault) @(negedge aclk);
  check_vaddr("write fault address", wr_pfault_vaddr, 32'h0003_7000);
  fill_entry(32'h0003_7000, 6'd3, 20'h37037);
  expect_req(1'b1, 32'h0003_7020, 64, 6'd3);
  ack_fault(1'b1);
  wait_drained();
  report_test("page fault");
endtask

task automatic test_both_dirs();
  mark = errors;
  fill_entry(32'h0005_2000, 6'd3, 20'h52052);
  fill_entry(32'h0007_3000, 6'd4, 20'h73073);
  expect_req(1'b0, 32'h0005_2100, 600, 6'd3);
  expect_req(1'b0, 32'h0005_2800, 1000, 6'd3);
  expect_req(1'b1, 32'h0007_3000, 512, 6'd4);
  expect_req(1'b1, 32'h0007_3f00, 256, 6'd4);
  fork
    begin
      send_req(1'b0, 32'h0005_2100, 16'd600, 6'd3);
      send_req(1'b0, 32'h0005_2800, 16'd1000, 6'd3);
    end
    begin
      send_req(1'b1, 32'h0007_3000, 16'd512, 6'd4);
      send_req(1'b1, 32'h0007_3f00, 16'd256, 6'd4);
    end
  join
  wait_drained();
  report_test("both dirs");
endtask

task automatic test_credits();
  int seen0;
  mark = errors;
  fill_entry(32'h0009_4000, 6'd3, 20'h94094);
  hold_xfer = 1'b1;
  seen0 = rd_seen;
  // Eight commands, only the credit count may pass
  expect_req(1'b0, 32'h0009_4000, 2048, 6'd3);
  send_req(1'b0, 32'h0009_4000, 16'd2048, 6'd3);
  while (rd_seen - seen0 < `MMU_N_CREDITS) @(negedge aclk);
  repeat (30) @(negedge aclk);
  checks++;
  if (rd_seen - seen0 != `MMU_N_CREDITS) begin
    errors++;
    $display("[FAIL] %0t ns: %0d commands without xfer, expected %0d", $time,
             rd_seen - seen0, `MMU_N_CREDITS);
  end
  hold_xfer = 1'b0;
  wait_drained();
  report_test("credits");
endtask

task automatic test_backpressure();
  vaddr_t va;
  int     len;
  logic   wr;
  mark = errors;
  for (int p = 0; p < 3; p++) begin
    rng = xorshift(rng);
    fill_entry(32'h0004_8000 + vaddr_t'(p * PG_SIZE), 6'd5, ppn_t'(rng));
  end
  bp_on = 1'b1;
  // Requests stay inside the three filled pages
  // Start in the first two, so even 4 KiB ends in the third
  for (int i = 0; i < 12; i++) begin
    rng = xorshift(rng);
    va  = 32'h0004_8000 + (rng % 32'h2000);
    rng = xorshift(rng);
    len = 1 + int'(rng % 32'd4096);
    wr  = rng[20];
    expect_req(wr, va, len, 6'd5);
    send_req(wr, va, len_t'(len), 6'd5);
  end
  wait_drained();
  bp_on = 1'b0;
  report_test("backpressure");
endtask

//--- dv/mmu_tb.sv
/*
 * MMU region testbench
 * Clock, reset, DUT, xorshift, TLB mirror, DMA sink model, compare tasks
 */
`timescale 1ns/100ps
`default_nettype none

`include "mmu_config.svh"

module mmu_tb import mmu_pkg::*; ();

  localparam int PG_SIZE   = 1 << `MMU_PG_BITS;
  localparam int N_ENTRIES = 1 << `MMU_TLB_ORDER;
  localparam int TAG_LSB   = `MMU_PG_BITS + `MMU_TLB_ORDER;
  localparam int XFER_BITS = $clog2(`MMU_XFER_BYTES);
  localparam logic [31:0] SEED = 32'h75be;
  // About 60 KiB over all tests is some 240 commands, so 20000 cycles leaves
  // plenty of room for faults and random back-pressure
  localparam int TIMEOUT_CYCLES = 20000;

  logic   aclk;
  logic   aresetn;
  logic   rd_req_valid, wr_req_valid;
  logic   rd_req_ready, wr_req_ready;
  vaddr_t rd_req_vaddr, wr_req_vaddr;
  len_t   rd_req_len, wr_req_len;
  pid_t   rd_req_pid, wr_req_pid;
  logic   fill_valid;
  vaddr_t fill_vaddr;
  pid_t   fill_pid;
  ppn_t   fill_ppn;
  logic   fill_entry_valid;
  logic   rd_pfault, wr_pfault;
  vaddr_t rd_pfault_vaddr, wr_pfault_vaddr;
  logic   rd_pfault_ack, wr_pfault_ack;
  logic   rd_dma_valid, wr_dma_valid;
  logic   rd_dma_ready, wr_dma_ready;
  paddr_t rd_dma_paddr, wr_dma_paddr;
  len_t   rd_dma_len, wr_dma_len;
  logic   rd_xfer, wr_xfer;

  // TLB mirror
  logic     m_valid [N_ENTRIES];
  tlb_tag_t m_tag   [N_ENTRIES];
  pid_t     m_pid   [N_ENTRIES];
  ppn_t     m_ppn   [N_ENTRIES];

  // Expected commands per port, in order
  paddr_t exp_rd_addr[$];
  len_t   exp_rd_len[$];
  paddr_t exp_wr_addr[$];
  len_t   exp_wr_len[$];

  logic [31:0] rng = SEED;
  logic [31:0] bp_rng;
  logic rd_fire, wr_fire;
  logic hold_xfer, bp_on;
  int rd_owed, wr_owed, rd_seen;
  int errors, checks, tests_run, mark, cycles;

  mmu_region_top UUT (.*);

  always #2 aclk = ~aclk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_cmd(input string port, input paddr_t got_addr, input len_t got_len,
                           input paddr_t exp_addr, input len_t exp_len);
    checks++;
    if (got_addr !== exp_addr || got_len !== exp_len) begin
      errors++;
      $display("[FAIL] %0t ns: %s command %h+%0d, expected %h+%0d", $time, port,
               got_addr, got_len, exp_addr, exp_len);
    end
  endtask

  task automatic check_vaddr(input string what, input vaddr_t got, input vaddr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------
  // DMA sink: monitor, ready and xfer model
  // ----------------------------------------
  // Values at the falling edge are those seen by the next rising edge
  always @(negedge aclk) begin
    rd_fire = aresetn && rd_dma_valid && rd_dma_ready;
    wr_fire = aresetn && wr_dma_valid && wr_dma_ready;
    if (rd_fire) begin
      rd_seen++;
      if (exp_rd_addr.size() == 0) begin
        errors++;
        $display("Read port gave a command nobody asked for at %0t ns", $time);
      end else begin
        check_cmd("read", rd_dma_paddr, rd_dma_len, exp_rd_addr.pop_front(),
                  exp_rd_len.pop_front());
      end
    end
    if (wr_fire) begin
      if (exp_wr_addr.size() == 0) begin
        errors++;
        $display("Write port gave a command nobody asked for at %0t ns", $time);
      end else begin
        check_cmd("write", wr_dma_paddr, wr_dma_len, exp_wr_addr.pop_front(),
                  exp_wr_len.pop_front());
      end
    end
  end

  // One xfer pulse per accepted command, owed pulses kept while held
  always @(posedge aclk) begin
    #1;
    rd_owed += int'(rd_fire);
    wr_owed += int'(wr_fire);
    rd_xfer = 1'b0;
    wr_xfer = 1'b0;
    if (!hold_xfer && rd_owed > 0) begin
      rd_xfer = 1'b1;
      rd_owed--;
    end
    if (!hold_xfer && wr_owed > 0) begin
      wr_xfer = 1'b1;
      wr_owed--;
    end
    if (bp_on) begin
      bp_rng = xorshift(bp_rng);
      rd_dma_ready = bp_rng[3];
      wr_dma_ready = bp_rng[9];
    end else begin
      rd_dma_ready = 1'b1;
      wr_dma_ready = 1'b1;
    end
  end

  always @(posedge aclk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ----------------------------------------
  // Drivers and reference model
  // ----------------------------------------
  task automatic fill_entry(input vaddr_t va, input pid_t pid, input ppn_t ppn);
    tlb_idx_t idx;
    idx = va[`MMU_PG_BITS +: `MMU_TLB_ORDER];
    @(posedge aclk);
    #1;
    fill_valid = 1'b1;
    fill_vaddr = va;
    fill_pid   = pid;
    fill_ppn   = ppn;
    @(posedge aclk);
    #1;
    fill_valid = 1'b0;
    m_valid[idx] = 1'b1;
    m_tag[idx]   = va[`MMU_VADDR_BITS-1:TAG_LSB];
    m_pid[idx]   = pid;
    m_ppn[idx]   = ppn;
  endtask

  task automatic send_req(input logic wr, input vaddr_t va, input len_t len, input pid_t pid);
    @(posedge aclk);
    #1;
    if (wr) begin
      wr_req_valid = 1'b1;
      wr_req_vaddr = va;
      wr_req_len   = len;
      wr_req_pid   = pid;
    end else begin
      rd_req_valid = 1'b1;
      rd_req_vaddr = va;
      rd_req_len   = len;
      rd_req_pid   = pid;
    end
    @(negedge aclk);
    while (!(wr ? wr_req_ready : rd_req_ready)) @(negedge aclk);
    @(posedge aclk);
    #1;
    if (wr) begin
      wr_req_valid = 1'b0;
    end else begin
      rd_req_valid = 1'b0;
    end
  endtask

  // Page walk, then cuts at each transfer-aligned boundary
  task automatic expect_req(input logic wr, input vaddr_t va, input int len, input pid_t pid);
    vaddr_t   cur;
    paddr_t   pa;
    tlb_idx_t idx;
    int       rem;
    int       run;
    int       piece;
    cur = va;
    rem = len;
    while (rem > 0) begin
      idx = cur[`MMU_PG_BITS +: `MMU_TLB_ORDER];
      if (!(m_valid[idx] && m_tag[idx] == cur[`MMU_VADDR_BITS-1:TAG_LSB] &&
            m_pid[idx] == pid)) begin
        errors++;
        $display("Test asked for commands on page %h, which is not in the TLB", cur);
        return;
      end
      run = PG_SIZE - int'(cur[`MMU_PG_BITS-1:0]);
      if (rem < run) run = rem;
      pa  = {m_ppn[idx], cur[`MMU_PG_BITS-1:0]};
      rem -= run;
      cur += vaddr_t'(run);
      while (run > 0) begin
        piece = `MMU_XFER_BYTES - int'(pa[XFER_BITS-1:0]);
        if (run < piece) piece = run;
        if (wr) begin
          exp_wr_addr.push_back(pa);
          exp_wr_len.push_back(len_t'(piece));
        end else begin
          exp_rd_addr.push_back(pa);
          exp_rd_len.push_back(len_t'(piece));
        end
        pa  += paddr_t'(piece);
        run -= piece;
      end
    end
  endtask

  task automatic ack_fault(input logic wr);
    @(posedge aclk);
    #1;
    if (wr) begin
      wr_pfault_ack = 1'b1;
    end else begin
      rd_pfault_ack = 1'b1;
    end
    @(posedge aclk);
    #1;
    rd_pfault_ack = 1'b0;
    wr_pfault_ack = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_rd_addr.size() != 0 || exp_wr_addr.size() != 0) @(negedge aclk);
    repeat (4) @(negedge aclk);
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == mark) begin
      $display("%-14s ok", name);
    end else begin
      $display("%-14s %0d errors", name, errors - mark);
    end
  endtask

  `include "mmu_tb_tests.svh"

  initial begin
    aclk = 1'b0;
    aresetn = 1'b0;
    {rd_req_valid, wr_req_valid, fill_valid, rd_pfault_ack, wr_pfault_ack} = '0;
    {rd_req_vaddr, wr_req_vaddr, fill_vaddr} = '0;
    {rd_req_len, wr_req_len, rd_req_pid, wr_req_pid, fill_pid, fill_ppn} = '0;
    fill_entry_valid = 1'b1;
    {rd_dma_ready, wr_dma_ready, rd_xfer, wr_xfer} = 4'b1100;
    {rd_fire, wr_fire, hold_xfer, bp_on} = '0;
    bp_rng = xorshift(SEED);
    for (int i = 0; i < N_ENTRIES; i++) m_valid[i] = 1'b0;
    repeat (3) @(posedge aclk);
    #1;
    aresetn = 1'b1;

    test_single_page();
    test_two_pages();
    test_page_fault();
    test_both_dirs();
    test_credits();
    test_backpressure();

    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+src
+incdir+dv
src/mmu_pkg.sv
src/mmu_if.sv
src/tlb_store.sv
src/tlb_lock.sv
src/xlat_fsm.sv
src/dma_splitter.sv
src/xfer_credits.sv
src/mmu_region_top.sv
dv/mmu_tb.sv

//--- Bender.yml
package:
  name: mmu_region

export_include_dirs:
  - src

sources:
  - src/mmu_pkg.sv
  - src/mmu_if.sv
  - src/tlb_store.sv
  - src/tlb_lock.sv
  - src/xlat_fsm.sv
  - src/dma_splitter.sv
  - src/xfer_credits.sv
  - src/mmu_region_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/mmu_tb.sv
